//--- sim.f
loader_pkg.sv
mem_write_port.sv
prg_loader.sv
crt_parser.sv
autostart_keys.sv
c64_loader_top.sv
c64_loader_asserts.sv
tb_c64_loader.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_c64_loader
RTL_TOP   ?= c64_loader_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "tests failed" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_c64_loader.sv
module tb_c64_loader;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int PRG_LEN   = 24;
	localparam int PRG_LOAD  = 'h0801;
	localparam int CHIP_SIZE = 'h2000;
	localparam int PKT_LEN   = loader_pkg::CHIP_HDR_LEN + CHIP_SIZE;
	localparam int CRT_LEN   = 'h40 + 2 * PKT_LEN;
	localparam int INIT_LEN  = int'(loader_pkg::MEMINIT_END);
	localparam int TIMEOUT_CYCLES = 2 * ((PRG_LEN + 2 + CRT_LEN + INIT_LEN) * 8 +
		loader_pkg::KEY_STEPS * (loader_pkg::KEY_GAP + 1));

	logic                          clk_sys;
	logic                          reset_n;
	loader_pkg::ioctl_t            ioctl;
	logic                          io_cycle;
	logic [loader_pkg::KEY_W-1:0]  ps2_key;
	logic                          ioctl_wait;
	logic                          mem_we;
	loader_pkg::mem_req_t          mem_req;
	logic [loader_pkg::KEY_W-1:0]  key;
	loader_pkg::cart_hdr_t         cart_hdr;
	logic                          cart_hdr_wr;
	logic                          cart_attached;

	logic [7:0]            mem [int];
	logic [7:0]            key_codes [$];
	loader_pkg::cart_hdr_t hdr_seen [$];
	logic [7:0]            last_code;
	logic [31:0]           lfsr;
	logic [1:0]            low_len;
	int                    phase_left;
	int                    cycle_cnt;
	int                    test_errors;
	int                    tests_run;
	int                    tests_failed;

	c64_loader_top c64_loader_top_i (
		.clk_sys        (clk_sys),
		.reset_n        (reset_n),
		.ioctl_i        (ioctl),
		.ioctl_wait_o   (ioctl_wait),
		.io_cycle_i     (io_cycle),
		.mem_we_o       (mem_we),
		.mem_req_o      (mem_req),
		.ps2_key_i      (ps2_key),
		.key_o          (key),
		.cart_hdr_o     (cart_hdr),
		.cart_hdr_wr_o  (cart_hdr_wr),
		.cart_attached_o(cart_attached)
	);

	initial clk_sys = 1'b0;
	always #5 clk_sys = ~clk_sys;

	// ====================
	// Stimulus data
	// ====================
	function automatic logic next_rand_bit();
		next_rand_bit = lfsr[0];
		lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	function automatic logic [7:0] prg_byte(int n);
		return 8'((n * 37) ^ 'h5C);
	endfunction

	function automatic logic [7:0] chip_byte(int chip, int i);
		return 8'(i ^ (i >> 8) ^ (chip * 'hA5));
	endfunction

	// Whole cartridge image with one byte per file offset
	function automatic logic [7:0] crt_file_byte(int ofs);
		int p;
		int chip;
		int q;
		if (ofs < 'h40) begin
			case (ofs)
				'h17: return 8'h13;
				'h19: return 8'h01;
				default: return 8'h00;
			endcase
		end
		p = ofs - 'h40;
		chip = p / PKT_LEN;
		q = p % PKT_LEN;
		case (q)
			0: return 8'h43;
			1: return 8'h48;
			2: return 8'h49;
			3: return 8'h50;
			6: return 8'(PKT_LEN >> 8);
			7: return 8'(PKT_LEN);
			9: return 8'h02;
			11: return 8'(chip);
			12: return 8'h80;
			14: return 8'(CHIP_SIZE >> 8);
			default: return (q < 16) ? 8'h00 : chip_byte(chip, q - 16);
		endcase
	endfunction

	// BASIC pointers after LOAD with bit 8 set on each pointer address
	function automatic logic [8:0] zp_expect(int a, logic [15:0] end_addr);
		case (a)
			'h2B: return 9'h101;
			'h2C: return 9'h108;
			'hAC, 'hAD: return 9'h100;
			'h2D, 'h2F, 'h31, 'hAE: return {1'b1, end_addr[7:0]};
			'h2E, 'h30, 'h32, 'hAF: return {1'b1, end_addr[15:8]};
			default: return 9'h000;
		endcase
	endfunction

	function automatic logic [7:0] mem_read(int a);
		return mem.exists(a) ? mem[a] : 8'hxx;
	endfunction

	// ====================
	// Core model and monitors
	// ====================
	always @(posedge clk_sys) begin
		if (phase_left == 0) begin
			if (io_cycle) begin
				low_len = {next_rand_bit(), next_rand_bit()};
				io_cycle <= 1'b0;
				phase_left <= int'(low_len);
			end else begin
				io_cycle <= 1'b1;
				phase_left <= 1;
			end
		end else begin
			phase_left <= phase_left - 1;
		end
	end

	always @(posedge clk_sys) begin
		if (reset_n && mem_we) begin
			mem[int'(mem_req.addr)] = mem_req.data;
		end
		if (reset_n && cart_hdr_wr) begin
			hdr_seen.push_back(cart_hdr);
		end
		if (reset_n && (key != ps2_key) && (key[7:0] != last_code)) begin
			key_codes.push_back(key[7:0]);
			last_code = key[7:0];
		end
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("tests failed");
			$finish;
		end
	end

	// ====================
	// Tasks
	// ====================
	task automatic check_value(string name, logic [127:0] exp, logic [127:0] act);
		if (act !== exp) begin
			$display("mismatch %s: expected %0h, actual %0h", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic report_test(string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("PASS %s", name);
		end else begin
			tests_failed++;
			$display("FAIL %s (%0d errors)", name, test_errors);
		end
		test_errors = 0;
	endtask

	// One byte per wr pulse and none while the port is busy
	task automatic send_byte(int addr, logic [7:0] data);
		@(posedge clk_sys);
		while (ioctl_wait) @(posedge clk_sys);
		ioctl.wr   <= 1'b1;
		ioctl.addr <= loader_pkg::ADDR_W'(addr);
		ioctl.data <= data;
		@(posedge clk_sys);
		ioctl.wr <= 1'b0;
	endtask

	task automatic set_download(logic [7:0] index, logic on);
		@(posedge clk_sys);
		ioctl.index    <= index;
		ioctl.download <= on;
	endtask

	// ====================
	// Test sequence
	// ====================
	initial begin
		logic [15:0] end_addr;
		logic [8:0]  zp;
		logic [7:0]  exp_keys [7];
		reset_n = 1'b0;
		ioctl = '0;
		io_cycle = 1'b1;
		ps2_key = 11'h1A5;
		lfsr = 32'hc143;
		phase_left = 0;
		cycle_cnt = 0;
		last_code = 8'h00;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		exp_keys = '{loader_pkg::PS2_SHIFT, loader_pkg::PS2_HOME, loader_pkg::PS2_SHIFT,
			loader_pkg::PS2_R, loader_pkg::PS2_U, loader_pkg::PS2_N, loader_pkg::PS2_RETURN};
		repeat (4) @(posedge clk_sys);
		reset_n <= 1'b1;

		repeat (8) begin
			@(posedge clk_sys);
			check_value("reset_idle we", 0, mem_we);
			check_value("reset_idle wait", 0, ioctl_wait);
			check_value("reset_idle key", ps2_key, key);
			check_value("reset_idle hdr_wr", 0, cart_hdr_wr);
			check_value("reset_idle attached", 0, cart_attached);
		end
		report_test("reset_idle");
		ps2_key <= '0;

		// PRG with load address 0801
		set_download(loader_pkg::IDX_PRG, 1'b1);
		send_byte(0, 8'(PRG_LOAD));
		send_byte(1, 8'(PRG_LOAD >> 8));
		for (int n = 0; n < PRG_LEN; n++) begin
			send_byte(n + 2, prg_byte(n));
		end
		set_download(loader_pkg::IDX_PRG, 1'b0);
		while (key_codes.size() == 0) @(posedge clk_sys);
		for (int n = 0; n < PRG_LEN; n++) begin
			check_value("prg_data", prg_byte(n), mem_read(PRG_LOAD + n));
		end
		report_test("prg_data");

		end_addr = 16'(PRG_LOAD + PRG_LEN);
		for (int a = 0; a < INIT_LEN; a++) begin
			zp = zp_expect(a, end_addr);
			if (zp[8]) begin
				check_value("prg_pointers", zp[7:0], mem_read(a));
			end else if (mem.exists(a)) begin
				$display("prg_pointers: unexpected write at zero page address %0h", a);
				test_errors++;
			end
		end
		report_test("prg_pointers");

		while ((key_codes.size() < 7) || (key != ps2_key)) @(posedge clk_sys);
		check_value("autostart count", 7, key_codes.size());
		for (int i = 0; i < 7; i++) begin
			check_value("autostart code", exp_keys[i], key_codes[i]);
		end
		// A fresh host key must show up unchanged
		ps2_key <= 11'h2F0;
		repeat (4) @(posedge clk_sys);
		check_value("autostart passthrough", ps2_key, key);
		report_test("autostart");

		// Cartridge with two 8 KB chips
		set_download(loader_pkg::IDX_CRT, 1'b1);
		for (int ofs = 0; ofs < CRT_LEN; ofs++) begin
			send_byte(ofs, crt_file_byte(ofs));
		end
		set_download(loader_pkg::IDX_CRT, 1'b0);
		@(posedge clk_sys);
		while (ioctl_wait) @(posedge clk_sys);
		repeat (3) @(posedge clk_sys);
		check_value("crt attached", 1, cart_attached);
		check_value("crt header count", 2, hdr_seen.size());
		for (int c = 0; c < hdr_seen.size(); c++) begin
			check_value("crt id", 16'h0013, hdr_seen[c].id);
			check_value("crt exrom", 8'h00, hdr_seen[c].exrom);
			check_value("crt game", 8'h01, hdr_seen[c].game);
			check_value("crt bank_type", 8'h02, hdr_seen[c].bank_type);
			check_value("crt bank_num", c, hdr_seen[c].bank_num);
			check_value("crt bank_laddr", 16'h8000, hdr_seen[c].bank_laddr);
			check_value("crt bank_size", CHIP_SIZE, hdr_seen[c].bank_size);
		end
		for (int c = 0; c < 2; c++) begin
			for (int i = 0; i < CHIP_SIZE; i++) begin
				check_value("crt data", chip_byte(c, i),
					mem_read(int'(loader_pkg::CRT_BASE) + c * CHIP_SIZE + i));
			end
		end
		report_test("crt_load");

		$display("tests: %0d run, %0d passed, %0d failed", tests_run,
			tests_run - tests_failed, tests_failed);
		if (tests_failed == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- c64_loader_asserts.sv
module c64_loader_asserts (
	input logic                      clk_sys,
	input logic                      reset_n,
	input loader_pkg::ioctl_t        ioctl_i,
	input logic                      ioctl_wait_o,
	input logic                      io_cycle_i,
	input logic                      mem_we_o,
	input logic [loader_pkg::KEY_W-1:0] key_o,
	input loader_pkg::key_step_e     key_step
);

	timeunit 1ns;
	timeprecision 1ps;

	// ====================
	// Memory write window
	// ====================
	// Single cycle write strobe
	we_one_cycle: assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem_we_o |=> !mem_we_o)
		else $error("mem_we_o held high for more than one cycle");

	// Write only right after io_cycle goes low
	we_after_fall: assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem_we_o |-> (!$past(io_cycle_i) && $past(io_cycle_i, 2)))
		else $error("mem_we_o outside the first cycle of a window");

	// Wait drops only together with the write
	wait_until_we: assert property (@(posedge clk_sys) disable iff (!reset_n)
		$fell(ioctl_wait_o) |-> mem_we_o)
		else $error("ioctl_wait_o dropped without a memory write");

	// ====================
	// Host and keyboard
	// ====================
	host_obeys_wait: assert property (@(posedge clk_sys) disable iff (!reset_n)
		ioctl_i.wr |-> !ioctl_wait_o)
		else $error("host raised wr while ioctl_wait_o was high");

	// Press and release flip only on a step change
	key_bit9_on_step: assert property (@(posedge clk_sys) disable iff (!reset_n)
		((key_step != loader_pkg::STEP_IDLE) && ($past(key_step) != loader_pkg::STEP_IDLE) &&
		(key_o[9] != $past(key_o[9]))) |-> (key_step != $past(key_step)))
		else $error("key_o bit 9 changed inside an autostart step");

endmodule

bind c64_loader_top c64_loader_asserts c64_loader_asserts_i (
	.clk_sys     (clk_sys),
	.reset_n     (reset_n),
	.ioctl_i     (ioctl_i),
	.ioctl_wait_o(ioctl_wait_o),
	.io_cycle_i  (io_cycle_i),
	.mem_we_o    (mem_we_o),
	.key_o       (key_o),
	.key_step    (autostart_keys_i.step)
);

//--- c64_loader_top.sv
module c64_loader_top (
	input  logic                         clk_sys,
	input  logic                         reset_n,
	input  loader_pkg::ioctl_t           ioctl_i,
	output logic                         ioctl_wait_o,
	input  logic                         io_cycle_i,
	output logic                         mem_we_o,
	output loader_pkg::mem_req_t         mem_req_o,
	input  logic [loader_pkg::KEY_W-1:0] ps2_key_i,
	output logic [loader_pkg::KEY_W-1:0] key_o,
	output loader_pkg::cart_hdr_t        cart_hdr_o,
	output logic                         cart_hdr_wr_o,
	output logic                         cart_attached_o
);

	loader_pkg::file_kind_e kind;
	logic                   busy;
	logic                   prg_req;
	logic                   crt_req;
	logic                   port_req;
	logic                   start_keys;
	loader_pkg::mem_req_t   prg_req_data;
	loader_pkg::mem_req_t   crt_req_data;
	loader_pkg::mem_req_t   port_req_data;

	// File kind from the download index
	always_comb begin
		if (ioctl_i.index == loader_pkg::IDX_PRG) begin
			kind = loader_pkg::KIND_PRG;
		end else if ((ioctl_i.index == loader_pkg::IDX_CRT) ||
				(ioctl_i.index == loader_pkg::IDX_CRT_ALT)) begin
			kind = loader_pkg::KIND_CRT;
		end else begin
			kind = loader_pkg::KIND_NONE;
		end
	end

	assign port_req      = (kind == loader_pkg::KIND_PRG) ? prg_req :
		(kind == loader_pkg::KIND_CRT) ? crt_req : 1'b0;
	assign port_req_data = (kind == loader_pkg::KIND_CRT) ? crt_req_data : prg_req_data;
	assign ioctl_wait_o  = busy;

	prg_loader prg_loader_i (
		.clk_sys   (clk_sys),
		.reset_n   (reset_n),
		.enable_i  (kind == loader_pkg::KIND_PRG),
		.ioctl_i   (ioctl_i),
		.busy_i    (busy),
		.req_o     (prg_req),
		.req_data_o(prg_req_data),
		.start_o   (start_keys)
	);

	crt_parser crt_parser_i (
		.clk_sys        (clk_sys),
		.reset_n        (reset_n),
		.enable_i       (kind == loader_pkg::KIND_CRT),
		.ioctl_i        (ioctl_i),
		.req_o          (crt_req),
		.req_data_o     (crt_req_data),
		.cart_hdr_o     (cart_hdr_o),
		.cart_hdr_wr_o  (cart_hdr_wr_o),
		.cart_attached_o(cart_attached_o)
	);

	mem_write_port mem_write_port_i (
		.clk_sys   (clk_sys),
		.reset_n   (reset_n),
		.req_i     (port_req),
		.req_data_i(port_req_data),
		.busy_o    (busy),
		.io_cycle_i(io_cycle_i),
		.mem_we_o  (mem_we_o),
		.mem_req_o (mem_req_o)
	);

	autostart_keys autostart_keys_i (
		.clk_sys  (clk_sys),
		.reset_n  (reset_n),
		.start_i  (start_keys),
		.ps2_key_i(ps2_key_i),
		.key_o    (key_o)
	);

endmodule

//--- autostart_keys.sv
module autostart_keys (
	input  logic                         clk_sys,
	input  logic                         reset_n,
	input  logic                         start_i,
	input  logic [loader_pkg::KEY_W-1:0] ps2_key_i,
	output logic [loader_pkg::KEY_W-1:0] key_o
);

	loader_pkg::key_step_e            step;
	logic [loader_pkg::KEY_GAP_W-1:0] gap_cnt;
	logic [loader_pkg::KEY_W-1:0]     key_q;
	logic [loader_pkg::KEY_W-1:0]     step_key;
	logic                             step_tick;

	assign step_tick = (gap_cnt == loader_pkg::KEY_GAP_W'(loader_pkg::KEY_GAP));

	// Key sent when leaving the current step
	always_comb begin
		step_key = key_q;
		case (step)
			loader_pkg::STEP_SHIFT,
			loader_pkg::STEP_UNSHIFT: step_key = {3'b000, loader_pkg::PS2_SHIFT};
			loader_pkg::STEP_HOME:    step_key = {3'b000, loader_pkg::PS2_HOME};
			loader_pkg::STEP_R:       step_key = {3'b000, loader_pkg::PS2_R};
			loader_pkg::STEP_U:       step_key = {3'b000, loader_pkg::PS2_U};
			loader_pkg::STEP_N:       step_key = {3'b000, loader_pkg::PS2_N};
			loader_pkg::STEP_RETURN:  step_key = {3'b000, loader_pkg::PS2_RETURN};
			default: ;
		endcase
		// Press or release follows the step parity
		step_key[9] = step[0];
	end

	// ====================
	// Step sequencer
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			step    <= loader_pkg::STEP_IDLE;
			gap_cnt <= '0;
		end else if (start_i) begin
			step    <= loader_pkg::STEP_SHIFT;
			gap_cnt <= '0;
		end else if (step != loader_pkg::STEP_IDLE) begin
			if (step_tick) begin
				gap_cnt <= '0;
				if (step == loader_pkg::STEP_END) begin
					step <= loader_pkg::STEP_IDLE;
				end else begin
					step <= loader_pkg::key_step_e'(step + 1'b1);
				end
			end else begin
				gap_cnt <= gap_cnt + 1'b1;
			end
		end
	end

	// Sequence starts from the last host key
	always_ff @(posedge clk_sys) begin
		if (step == loader_pkg::STEP_IDLE) begin
			key_q <= ps2_key_i;
		end else if (step_tick) begin
			key_q <= step_key;
		end
	end

	assign key_o = (step == loader_pkg::STEP_IDLE) ? ps2_key_i : key_q;

endmodule

//--- crt_parser.sv
module crt_parser (
	input  logic                  clk_sys,
	input  logic                  reset_n,
	input  logic                  enable_i,
	input  loader_pkg::ioctl_t    ioctl_i,
	output logic                  req_o,
	output loader_pkg::mem_req_t  req_data_o,
	output loader_pkg::cart_hdr_t cart_hdr_o,
	output logic                  cart_hdr_wr_o,
	output logic                  cart_attached_o
);

	localparam int HDR_CNT_W = $clog2(loader_pkg::CHIP_HDR_LEN);

	logic                          download_d;
	logic                          chip_byte;
	logic                          hdr_byte;
	logic [HDR_CNT_W-1:0]          hdr_cnt;
	logic [31:0]                   blk_len;
	logic [loader_pkg::ADDR_W-1:0] load_addr;

	// Anything past the file header belongs to a chip packet
	assign chip_byte = enable_i && ioctl_i.wr && (ioctl_i.addr >= loader_pkg::CRT_DATA_START);
	assign hdr_byte  = chip_byte && (hdr_cnt != '0);

	assign req_o = chip_byte && (hdr_cnt == '0) && (blk_len != '0);

	always_comb begin
		req_data_o.addr = load_addr;
		req_data_o.data = ioctl_i.data;
	end

	// ====================
	// Packet walk
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			download_d      <= 1'b0;
			hdr_cnt         <= '0;
			blk_len         <= '0;
			load_addr       <= loader_pkg::CRT_BASE;
			cart_hdr_wr_o   <= 1'b0;
			cart_attached_o <= 1'b0;
		end else begin
			download_d    <= ioctl_i.download;
			cart_hdr_wr_o <= 1'b0;
			if (enable_i && ioctl_i.wr && (ioctl_i.addr == '0)) begin
				load_addr <= loader_pkg::CRT_BASE;
				blk_len   <= '0;
				hdr_cnt   <= '0;
			end
			if (chip_byte) begin
				if ((hdr_cnt == '0) && (blk_len == '0)) begin
					// New chip packet, data starts on an 8 KB boundary
					hdr_cnt <= 1;
					if (load_addr[12:0] != '0) begin
						load_addr <= {load_addr[loader_pkg::ADDR_W-1:13] + 1'b1, 13'd0};
					end
				end else if (hdr_cnt != '0) begin
					hdr_cnt <= hdr_cnt + 1'b1;
					case (hdr_cnt)
						4:       blk_len[31:24] <= ioctl_i.data;
						5:       blk_len[23:16] <= ioctl_i.data;
						6:       blk_len[15:8]  <= ioctl_i.data;
						7:       blk_len[7:0]   <= ioctl_i.data;
						// Packet length counts its own header
						8:       blk_len <= blk_len - 32'(loader_pkg::CHIP_HDR_LEN);
						15:      cart_hdr_wr_o  <= 1'b1;
						default: ;
					endcase
				end else begin
					blk_len   <= blk_len - 1'b1;
					load_addr <= load_addr + 1'b1;
				end
			end
			// Detached while loading, attached once the file is in
			if (enable_i && (download_d != ioctl_i.download)) begin
				cart_attached_o <= download_d;
			end
		end
	end

	// ====================
	// Header fields
	// ====================
	always_ff @(posedge clk_sys) begin
		if (enable_i && ioctl_i.wr) begin
			if (ioctl_i.addr == loader_pkg::CRT_OFS_ID) begin
				cart_hdr_o.id[15:8] <= ioctl_i.data;
			end
			if (ioctl_i.addr == loader_pkg::CRT_OFS_ID + 1'b1) begin
				cart_hdr_o.id[7:0] <= ioctl_i.data;
			end
			if (ioctl_i.addr == loader_pkg::CRT_OFS_EXROM) begin
				cart_hdr_o.exrom <= ioctl_i.data;
			end
			if (ioctl_i.addr == loader_pkg::CRT_OFS_GAME) begin
				cart_hdr_o.game <= ioctl_i.data;
			end
		end
		if (hdr_byte) begin
			case (hdr_cnt)
				9:       cart_hdr_o.bank_type        <= ioctl_i.data;
				10:      cart_hdr_o.bank_num[15:8]   <= ioctl_i.data;
				11:      cart_hdr_o.bank_num[7:0]    <= ioctl_i.data;
				12:      cart_hdr_o.bank_laddr[15:8] <= ioctl_i.data;
				13:      cart_hdr_o.bank_laddr[7:0]  <= ioctl_i.data;
				14:      cart_hdr_o.bank_size[15:8]  <= ioctl_i.data;
				15:      cart_hdr_o.bank_size[7:0]   <= ioctl_i.data;
				default: ;
			endcase
		end
	end

endmodule

//--- prg_loader.sv
module prg_loader (
	input  logic                 clk_sys,
	input  logic                 reset_n,
	input  logic                 enable_i,
	input  loader_pkg::ioctl_t   ioctl_i,
	input  logic                 busy_i,
	output logic                 req_o,
	output loader_pkg::mem_req_t req_data_o,
	output logic                 start_o
);

	typedef enum logic [1:0] {
		PRG_LOAD,
		PRG_INIT_SCAN,
		PRG_INIT_WAIT
	} prg_state_e;

	prg_state_e                    state;
	logic                          download_d;
	logic                          meminit_d;
	logic                          meminit;
	logic                          data_wr;
	logic                          init_req;
	logic                          init_hit;
	logic [7:0]                    init_data;
	logic [15:0]                   load_addr;
	logic [15:0]                   end_addr;
	logic [loader_pkg::ADDR_W-1:0] init_addr;

	assign meminit = (state != PRG_LOAD);

	// Bytes from offset 2 on are program data
	assign data_wr = enable_i && (state == PRG_LOAD) && ioctl_i.wr &&
		(ioctl_i.addr[loader_pkg::ADDR_W-1:1] != '0);

	// BASIC pointer values, as left behind by LOAD
	always_comb begin
		init_hit  = 1'b1;
		init_data = 8'h00;
		case (init_addr[7:0])
			loader_pkg::ZP_TXT:             init_data = 8'h01;
			loader_pkg::ZP_TXT + 8'd1:      init_data = 8'h08;
			loader_pkg::ZP_SAVE,
			loader_pkg::ZP_SAVE + 8'd1:     init_data = 8'h00;
			loader_pkg::ZP_VAR,
			loader_pkg::ZP_ARY,
			loader_pkg::ZP_STR,
			loader_pkg::ZP_LOAD_END:        init_data = end_addr[7:0];
			loader_pkg::ZP_VAR + 8'd1,
			loader_pkg::ZP_ARY + 8'd1,
			loader_pkg::ZP_STR + 8'd1,
			loader_pkg::ZP_LOAD_END + 8'd1: init_data = end_addr[15:8];
			default:                        init_hit = 1'b0;
		endcase
	end

	assign init_req = (state == PRG_INIT_SCAN) && (init_addr != loader_pkg::MEMINIT_END) &&
		init_hit && !busy_i;

	assign req_o = data_wr || init_req;

	always_comb begin
		if (state == PRG_LOAD) begin
			req_data_o.addr = {{(loader_pkg::ADDR_W - 16){1'b0}}, load_addr};
			req_data_o.data = ioctl_i.data;
		end else begin
			req_data_o.addr = init_addr;
			req_data_o.data = init_data;
		end
	end

	// ====================
	// Meminit FSM
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state      <= PRG_LOAD;
			init_addr  <= '0;
			download_d <= 1'b0;
			meminit_d  <= 1'b0;
			start_o    <= 1'b0;
		end else begin
			download_d <= ioctl_i.download;
			meminit_d  <= meminit;
			start_o    <= meminit_d && !meminit;
			case (state)
				PRG_LOAD: begin
					if (enable_i && download_d && !ioctl_i.download) begin
						state     <= PRG_INIT_SCAN;
						init_addr <= '0;
					end
				end
				PRG_INIT_SCAN: begin
					if (init_addr == loader_pkg::MEMINIT_END) begin
						state <= PRG_LOAD;
					end else if (init_hit) begin
						// Last data byte may still sit in the port
						if (!busy_i) begin
							state <= PRG_INIT_WAIT;
						end
					end else begin
						init_addr <= init_addr + 1'b1;
					end
				end
				default: begin
					if (!busy_i) begin
						init_addr <= init_addr + 1'b1;
						state     <= PRG_INIT_SCAN;
					end
				end
			endcase
		end
	end

	// Load and end address from the two header bytes
	always_ff @(posedge clk_sys) begin
		if (enable_i && (state == PRG_LOAD) && ioctl_i.wr) begin
			if (ioctl_i.addr == '0) begin
				load_addr[7:0] <= ioctl_i.data;
				end_addr[7:0]  <= ioctl_i.data;
			end else if (ioctl_i.addr == 1) begin
				load_addr[15:8] <= ioctl_i.data;
				end_addr[15:8]  <= ioctl_i.data;
			end else begin
				load_addr <= load_addr + 1'b1;
				end_addr  <= end_addr + 1'b1;
			end
		end
	end

endmodule

//--- mem_write_port.sv
module mem_write_port (
	input  logic                 clk_sys,
	input  logic                 reset_n,
	input  logic                 req_i,
	input  loader_pkg::mem_req_t req_data_i,
	output logic                 busy_o,
	input  logic                 io_cycle_i,
	output logic                 mem_we_o,
	output loader_pkg::mem_req_t mem_req_o
);

	logic                 pending;
	logic                 io_cycle_d;
	logic                 window_start;
	loader_pkg::mem_req_t held_q;

	// First low cycle of io_cycle opens a write window
	assign window_start = io_cycle_d & ~io_cycle_i;

	// ====================
	// Buffer control
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			pending    <= 1'b0;
			io_cycle_d <= 1'b0;
			mem_we_o   <= 1'b0;
		end else begin
			io_cycle_d <= io_cycle_i;
			mem_we_o   <= 1'b0;
			if (pending && window_start) begin
				// Write goes out and the entry frees in the same cycle
				mem_we_o <= 1'b1;
				pending  <= 1'b0;
			end else if (req_i && !pending) begin
				pending <= 1'b1;
			end
		end
	end

	// Held request, stable while the write is on the bus
	always_ff @(posedge clk_sys) begin
		if (req_i && !pending) begin
			held_q <= req_data_i;
		end
	end

	assign busy_o    = pending;
	assign mem_req_o = held_q;

endmodule

//--- loader_pkg.sv
package loader_pkg;

	// ====================
	// Memory and file layout
	// ====================
	localparam int ADDR_W = 25;
	localparam int KEY_W  = 11;

	// ioctl index codes
	localparam logic [7:0] IDX_PRG     = 8'h04;
	localparam logic [7:0] IDX_CRT     = 8'h05;
	localparam logic [7:0] IDX_CRT_ALT = 8'hC0;

	localparam logic [ADDR_W-1:0] CRT_BASE       = 25'h100000;
	localparam logic [ADDR_W-1:0] MEMINIT_END    = 25'h000100;
	localparam logic [ADDR_W-1:0] CRT_DATA_START = 25'h000040;

	// Cartridge file header offsets
	localparam logic [ADDR_W-1:0] CRT_OFS_ID    = 25'h000016;
	localparam logic [ADDR_W-1:0] CRT_OFS_EXROM = 25'h000018;
	localparam logic [ADDR_W-1:0] CRT_OFS_GAME  = 25'h000019;
	localparam int CHIP_HDR_LEN = 16;

	// Zero page BASIC pointers, low byte address of each pair
	localparam logic [7:0] ZP_TXT      = 8'h2B;
	localparam logic [7:0] ZP_VAR      = 8'h2D;
	localparam logic [7:0] ZP_ARY      = 8'h2F;
	localparam logic [7:0] ZP_STR      = 8'h31;
	localparam logic [7:0] ZP_SAVE     = 8'hAC;
	localparam logic [7:0] ZP_LOAD_END = 8'hAE;

	// ====================
	// Autostart key table
	// ====================
	localparam int KEY_GAP    = 64;
	localparam int KEY_GAP_W  = $clog2(KEY_GAP + 1);
	localparam int KEY_STEPS  = 16;
	localparam int KEY_STEP_W = $clog2(KEY_STEPS);

	localparam logic [7:0] PS2_SHIFT  = 8'h12;
	localparam logic [7:0] PS2_HOME   = 8'h6C;
	localparam logic [7:0] PS2_R      = 8'h2D;
	localparam logic [7:0] PS2_U      = 8'h3C;
	localparam logic [7:0] PS2_N      = 8'h31;
	localparam logic [7:0] PS2_RETURN = 8'h5A;

	// ====================
	// Types
	// ====================
	typedef enum logic [1:0] {
		KIND_NONE,
		KIND_PRG,
		KIND_CRT
	} file_kind_e;

	// Step 0 is pass-through, step 15 ends the sequence
	typedef enum logic [KEY_STEP_W-1:0] {
		STEP_IDLE,
		STEP_SHIFT,
		STEP_HOME,
		STEP_HOLD_3,
		STEP_HOLD_4,
		STEP_UNSHIFT,
		STEP_HOLD_6,
		STEP_R,
		STEP_HOLD_8,
		STEP_U,
		STEP_HOLD_10,
		STEP_N,
		STEP_HOLD_12,
		STEP_RETURN,
		STEP_HOLD_14,
		STEP_END
	} key_step_e;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [7:0]        data;
	} mem_req_t;

	typedef struct packed {
		logic              download;
		logic              wr;
		logic [7:0]        index;
		logic [ADDR_W-1:0] addr;
		logic [7:0]        data;
	} ioctl_t;

	typedef struct packed {
		logic [15:0] id;
		logic [7:0]  exrom;
		logic [7:0]  game;
		logic [7:0]  bank_type;
		logic [15:0] bank_num;
		logic [15:0] bank_laddr;
		logic [15:0] bank_size;
	} cart_hdr_t;

endpackage
